/* tb.f */
+incdir+src
src/simplebus_pkg.sv
src/simplebus_if.sv
src/timer_ctrl_if.sv
src/simplebus_interconnect.sv
src/timer_registers.sv
src/timer_core.sv
src/timer_subsystem.sv
dv/timer_subsystem_sva.sv
dv/timer_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= timer_subsystem_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

/* dv/timer_subsystem_tb.sv */
`include "simplebus_defs.svh"

module timer_subsystem_tb;

    localparam int RANDOM_OPS = 40;
    // Reset, directed reads, contended traffic, timer sequence, then a margin
    localparam int TEST_CYCLES = 5 + 40 + RANDOM_OPS * 12 + 150 + 200;

    localparam logic [31:0] SCRATCH_ADDR = `TIMER_BASE + 32'h10;
    localparam logic [31:0] MISS_ADDR = 32'h5000_0000;

    logic clock = 1'b0;
    logic reset;
    logic [`SB_ADDR_WIDTH-1:0] m1_address, m2_address, m3_address;
    logic [`SB_DATA_WIDTH-1:0] m1_write_data, m2_write_data, m3_write_data;
    logic m1_read_strobe, m2_read_strobe, m3_read_strobe;
    logic m1_write_strobe, m2_write_strobe, m3_write_strobe;
    logic [`SB_DATA_WIDTH-1:0] m1_read_data, m2_read_data, m3_read_data;
    logic m1_read_valid, m2_read_valid, m3_read_valid;
    logic m1_ready, m2_ready, m3_ready;
    logic irq;
    int total_errors;
    logic [31:0] reload_value;

    timer_subsystem timer_subsystem_i (.*);

    bind timer_subsystem timer_subsystem_sva sva_i (.*);

    always #4 clock = ~clock;

    task automatic drive_request(input int master, input logic rd, input logic wr,
                                 input logic [31:0] addr, input logic [31:0] data);
        case (master)
            1: begin
                m1_address <= addr;
                m1_write_data <= data;
                m1_read_strobe <= rd;
                m1_write_strobe <= wr;
            end
            2: begin
                m2_address <= addr;
                m2_write_data <= data;
                m2_read_strobe <= rd;
                m2_write_strobe <= wr;
            end
            default: begin
                m3_address <= addr;
                m3_write_data <= data;
                m3_read_strobe <= rd;
                m3_write_strobe <= wr;
            end
        endcase
    endtask

    // Called just after a rising edge, returns on the accepting edge
    task automatic bus_access(input int master, input logic is_write,
                              input logic [31:0] addr, input logic [31:0] data);
        logic accepted;
        accepted = 1'b0;
        drive_request(master, !is_write, is_write, addr, data);
        while (!accepted) begin
            @(posedge clock);
            accepted = (master == 1) ? m1_ready : (master == 2) ? m2_ready : m3_ready;
        end
        drive_request(master, 1'b0, 1'b0, addr, data);
    endtask

    task automatic random_traffic(input int master);
        logic [31:0] value;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            value = $urandom;
            case (value[9:8])
                2'd0: bus_access(master, 1'b1, SCRATCH_ADDR, value);
                2'd1: bus_access(master, 1'b0, SCRATCH_ADDR, '0);
                2'd2: bus_access(master, 1'b0, MISS_ADDR + {24'd0, value[7:2], 2'b00}, '0);
                default: repeat (value[1:0]) @(posedge clock);
            endcase
        end
    endtask

    initial begin
        void'($urandom(64));
        reset = 1'b1;
        drive_request(1, 1'b0, 1'b0, '0, '0);
        drive_request(2, 1'b0, 1'b0, '0, '0);
        drive_request(3, 1'b0, 1'b0, '0, '0);
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);

        // Scratch written by one master, read back by the others and a miss
        bus_access(1, 1'b1, SCRATCH_ADDR, $urandom);
        bus_access(2, 1'b0, SCRATCH_ADDR, '0);
        bus_access(3, 1'b0, MISS_ADDR, '0);
        bus_access(1, 1'b0, `TIMER_LIMIT + 32'h4, '0);
        repeat (4) @(posedge clock);

        fork
            random_traffic(1);
            random_traffic(2);
            random_traffic(3);
        join
        repeat (4) @(posedge clock);

        // Timer expiry, interrupt enable ordering and status clear
        reload_value = {28'd0, 4'($urandom)} + 32'd4;
        bus_access(1, 1'b1, `TIMER_BASE + 32'h4, reload_value);
        bus_access(1, 1'b1, `TIMER_BASE, 32'h2);
        bus_access(1, 1'b1, `TIMER_BASE, 32'h3);
        for (int i = 0; i < reload_value + 12 && !irq; i++) begin
            @(posedge clock);
        end
        bus_access(1, 1'b1, `TIMER_BASE, 32'h2);
        bus_access(1, 1'b1, `TIMER_BASE + 32'hC, 32'h1);
        for (int i = 0; i < 8 && irq; i++) begin
            @(posedge clock);
        end

        // Timer running with the interrupt masked
        bus_access(1, 1'b1, `TIMER_BASE, 32'h1);
        repeat (reload_value + 8) @(posedge clock);
        bus_access(1, 1'b1, `TIMER_BASE, 32'h0);
        repeat (5) @(posedge clock);

        total_errors = timer_subsystem_i.sva_i.reset_errors
            + timer_subsystem_i.sva_i.priority_errors
            + timer_subsystem_i.sva_i.routing_errors
            + timer_subsystem_i.sva_i.data_errors
            + timer_subsystem_i.sva_i.irq_errors;
        $display("Errors: reset %0d priority %0d routing %0d data %0d irq %0d total %0d",
                 timer_subsystem_i.sva_i.reset_errors,
                 timer_subsystem_i.sva_i.priority_errors,
                 timer_subsystem_i.sva_i.routing_errors,
                 timer_subsystem_i.sva_i.data_errors,
                 timer_subsystem_i.sva_i.irq_errors, total_errors);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TEST_CYCLES * 8);
        $display("Timeout: the tests did not finish in %0d cycles", TEST_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* dv/timer_subsystem_sva.sv */
`include "simplebus_defs.svh"

module timer_subsystem_sva
    import simplebus_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic [`SB_ADDR_WIDTH-1:0] m1_address, m2_address, m3_address,
    input logic [`SB_DATA_WIDTH-1:0] m1_write_data, m2_write_data, m3_write_data,
    input logic m1_read_strobe, m2_read_strobe, m3_read_strobe,
    input logic m1_write_strobe, m2_write_strobe, m3_write_strobe,
    input logic [`SB_DATA_WIDTH-1:0] m1_read_data, m2_read_data, m3_read_data,
    input logic m1_read_valid, m2_read_valid, m3_read_valid,
    input logic m1_ready, m2_ready, m3_ready,
    input logic irq
);

    int reset_errors = 0;
    int priority_errors = 0;
    int routing_errors = 0;
    int data_errors = 0;
    int irq_errors = 0;

    logic [2:0] request;
    logic [2:0] granted;
    logic [2:0] valid;
    logic [2:0] expected_valid;
    logic accept_read;
    logic accept_write;
    logic in_window;
    master_id_t accept_id;
    logic [`SB_ADDR_WIDTH-1:0] accept_address;
    logic [`SB_DATA_WIDTH-1:0] accept_data;
    logic [`SB_DATA_WIDTH-1:0] response_data;

    // Reference state rebuilt from the top-level ports
    logic scratch_known;
    logic [`SB_DATA_WIDTH-1:0] scratch_shadow;
    logic [`SB_DATA_WIDTH-1:0] reload_shadow;
    logic irq_enable_shadow;
    logic [2:0] irq_enable_history;
    logic rise_pending;
    logic fall_pending;
    logic [`SB_DATA_WIDTH-1:0] rise_left;
    logic [3:0] fall_left;

    // Three-stage expectation pipeline, stage 2 lines up with the response
    logic [2:0] read_pipe;
    logic [2:0] check_pipe;
    master_id_t id_pipe [3];
    logic [`SB_DATA_WIDTH-1:0] expect_pipe [3];

    assign request = {m3_read_strobe | m3_write_strobe, m2_read_strobe | m2_write_strobe,
                      m1_read_strobe | m1_write_strobe};
    assign granted = request & {m3_ready, m2_ready, m1_ready};
    assign valid = {m3_read_valid, m2_read_valid, m1_read_valid};

    always_comb begin
        accept_id = MASTER_3;
        accept_address = m3_address;
        accept_data = m3_write_data;
        accept_read = granted[2] && !m3_write_strobe;
        if (granted[0]) begin
            accept_id = MASTER_1;
            accept_address = m1_address;
            accept_data = m1_write_data;
            accept_read = !m1_write_strobe;
        end else if (granted[1]) begin
            accept_id = MASTER_2;
            accept_address = m2_address;
            accept_data = m2_write_data;
            accept_read = !m2_write_strobe;
        end
    end

    assign accept_write = (|granted) && !accept_read;
    assign in_window = (accept_address >= `TIMER_BASE) && (accept_address < `TIMER_LIMIT);
    assign expected_valid = read_pipe[2] ? (3'b001 << id_pipe[2]) : 3'b000;
    assign response_data = (id_pipe[2] == MASTER_1) ? m1_read_data :
                           (id_pipe[2] == MASTER_2) ? m2_read_data : m3_read_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            scratch_known <= 1'b0;
            reload_shadow <= '0;
            irq_enable_shadow <= 1'b0;
            irq_enable_history <= '0;
            rise_pending <= 1'b0;
            fall_pending <= 1'b0;
            read_pipe <= '0;
            check_pipe <= '0;
        end else begin
            if (accept_write && in_window) begin
                case (accept_address[4:0])
                    REG_SCRATCH: begin
                        scratch_shadow <= accept_data;
                        scratch_known <= 1'b1;
                    end
                    REG_RELOAD: reload_shadow <= accept_data;
                    REG_CTRL: irq_enable_shadow <= accept_data[1];
                    default: ;
                endcase
            end
            irq_enable_history <= {irq_enable_history[1:0], irq_enable_shadow};
            if (accept_write && in_window && accept_address[4:0] == REG_CTRL
                    && accept_data[1:0] == 2'b11) begin
                rise_pending <= 1'b1;
                rise_left <= reload_shadow + 32'd8;
            end else if (rise_pending) begin
                if (irq) begin
                    rise_pending <= 1'b0;
                end else begin
                    rise_left <= rise_left - 32'd1;
                end
            end
            if (accept_write && in_window && accept_address[4:0] == REG_STATUS
                    && accept_data[0]) begin
                fall_pending <= 1'b1;
                fall_left <= 4'd5;
            end else if (fall_pending) begin
                if (!irq) begin
                    fall_pending <= 1'b0;
                end else begin
                    fall_left <= fall_left - 4'd1;
                end
            end
            read_pipe <= {read_pipe[1:0], accept_read};
            check_pipe <= {check_pipe[1:0], accept_read
                && (!in_window || (accept_address[4:0] == REG_SCRATCH && scratch_known))};
            id_pipe[0] <= accept_id;
            id_pipe[1] <= id_pipe[0];
            id_pipe[2] <= id_pipe[1];
            expect_pipe[0] <= in_window ? scratch_shadow : `SB_DECODE_ERROR_DATA;
            expect_pipe[1] <= expect_pipe[0];
            expect_pipe[2] <= expect_pipe[1];
        end
    end

    reset_state: assert property (@(posedge clock)
        reset |=> (valid == 3'b000 && !irq && m1_ready))
        else begin
            reset_errors++;
            $error("[FAIL] reset_state expected valid 000 irq 0 ready 1, actual %b %b %b",
                   valid, irq, m1_ready);
        end

    fixed_priority: assert property (@(posedge clock) disable iff (reset)
        !(request[0] && (m2_ready || m3_ready)) && !(request[1] && !request[0] && m3_ready))
        else begin
            priority_errors++;
            $error("A lower-priority master was ready while a higher one was strobing");
        end

    read_routing: assert property (@(posedge clock) disable iff (reset)
        valid == expected_valid)
        else begin
            routing_errors++;
            $error("[FAIL] read_routing expected %b actual %b", expected_valid, valid);
        end

    read_data: assert property (@(posedge clock) disable iff (reset)
        check_pipe[2] |-> response_data == expect_pipe[2])
        else begin
            data_errors++;
            $error("[FAIL] read_data expected %h actual %h", expect_pipe[2], response_data);
        end

    interrupt: assert property (@(posedge clock) disable iff (reset)
        !(irq && !irq_enable_shadow && irq_enable_history == 3'b000)
        && !(rise_pending && rise_left == 0) && !(fall_pending && fall_left == 0))
        else begin
            irq_errors++;
            $error("Interrupt missed its deadline or was high with irq_enable clear");
        end

endmodule

/* src/timer_subsystem.sv */
`include "simplebus_defs.svh"

module timer_subsystem (
    input logic clock,
    input logic reset,

    input logic [`SB_ADDR_WIDTH-1:0] m1_address,
    input logic [`SB_DATA_WIDTH-1:0] m1_write_data,
    input logic m1_read_strobe,
    input logic m1_write_strobe,
    output logic [`SB_DATA_WIDTH-1:0] m1_read_data,
    output logic m1_read_valid,
    output logic m1_ready,

    input logic [`SB_ADDR_WIDTH-1:0] m2_address,
    input logic [`SB_DATA_WIDTH-1:0] m2_write_data,
    input logic m2_read_strobe,
    input logic m2_write_strobe,
    output logic [`SB_DATA_WIDTH-1:0] m2_read_data,
    output logic m2_read_valid,
    output logic m2_ready,

    input logic [`SB_ADDR_WIDTH-1:0] m3_address,
    input logic [`SB_DATA_WIDTH-1:0] m3_write_data,
    input logic m3_read_strobe,
    input logic m3_write_strobe,
    output logic [`SB_DATA_WIDTH-1:0] m3_read_data,
    output logic m3_read_valid,
    output logic m3_ready,

    output logic irq
);

    simplebus_if m1_bus ();
    simplebus_if m2_bus ();
    simplebus_if m3_bus ();
    simplebus_if timer_bus ();
    timer_ctrl_if timer_ctrl ();

    // Master 1 port wiring
    assign m1_bus.address = m1_address;
    assign m1_bus.write_data = m1_write_data;
    assign m1_bus.read_strobe = m1_read_strobe;
    assign m1_bus.write_strobe = m1_write_strobe;
    assign m1_read_data = m1_bus.read_data;
    assign m1_read_valid = m1_bus.read_valid;
    assign m1_ready = m1_bus.ready;

    // Master 2 port wiring
    assign m2_bus.address = m2_address;
    assign m2_bus.write_data = m2_write_data;
    assign m2_bus.read_strobe = m2_read_strobe;
    assign m2_bus.write_strobe = m2_write_strobe;
    assign m2_read_data = m2_bus.read_data;
    assign m2_read_valid = m2_bus.read_valid;
    assign m2_ready = m2_bus.ready;

    // Master 3 port wiring
    assign m3_bus.address = m3_address;
    assign m3_bus.write_data = m3_write_data;
    assign m3_bus.read_strobe = m3_read_strobe;
    assign m3_bus.write_strobe = m3_write_strobe;
    assign m3_read_data = m3_bus.read_data;
    assign m3_read_valid = m3_bus.read_valid;
    assign m3_ready = m3_bus.ready;

    simplebus_interconnect interconnect_i (
        .clock(clock),
        .reset(reset),
        .master_1(m1_bus.slave),
        .master_2(m2_bus.slave),
        .master_3(m3_bus.slave),
        .slave(timer_bus.master)
    );

    timer_registers registers_i (
        .clock(clock),
        .reset(reset),
        .bus(timer_bus.slave),
        .timer(timer_ctrl.regs),
        .irq(irq)
    );

    timer_core core_i (
        .clock(clock),
        .reset(reset),
        .ctrl(timer_ctrl.core)
    );

endmodule

/* src/timer_core.sv */
`include "simplebus_defs.svh"

module timer_core (
    input logic clock,
    input logic reset,
    timer_ctrl_if.core ctrl
);

    logic [`SB_DATA_WIDTH-1:0] count;
    logic wrap;

    // Expiry is the cycle in which the count sits on the reload value
    assign wrap = ctrl.enable && (count == ctrl.reload);

    assign ctrl.expired = wrap;
    assign ctrl.count = count;

    // Count holds its value while disabled
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (ctrl.enable) begin
            if (wrap) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

/* src/timer_registers.sv */
`include "simplebus_defs.svh"

module timer_registers
    import simplebus_pkg::*;
(
    input logic clock,
    input logic reset,
    simplebus_if.slave bus,
    timer_ctrl_if.regs timer,
    output logic irq
);

    timer_reg_t offset;
    logic enable;
    logic irq_enable;
    logic expired_status;
    logic clear_status;
    logic [`SB_DATA_WIDTH-1:0] reload;
    logic [`SB_DATA_WIDTH-1:0] scratch;
    logic [`SB_DATA_WIDTH-1:0] read_value;

    // Window is 32 bytes, the low address bits select the register
    assign offset = timer_reg_t'(bus.address[4:0]);

    // Every strobe is taken as it comes
    assign bus.ready = 1'b1;

    assign timer.enable = enable;
    assign timer.reload = reload;

    assign irq = expired_status & irq_enable;

    always_ff @(posedge clock) begin
        if (reset) begin
            enable <= 1'b0;
            irq_enable <= 1'b0;
            reload <= '0;
        end else if (bus.write_strobe) begin
            case (offset)
                REG_CTRL: begin
                    enable <= bus.write_data[0];
                    irq_enable <= bus.write_data[1];
                end
                REG_RELOAD: reload <= bus.write_data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (bus.write_strobe && (offset == REG_SCRATCH)) begin
            scratch <= bus.write_data;
        end
    end

    assign clear_status = bus.write_strobe && (offset == REG_STATUS) && bus.write_data[0];

    // Sticky expiry flag, a new expiry wins over a clear in the same cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            expired_status <= 1'b0;
        end else if (timer.expired) begin
            expired_status <= 1'b1;
        end else if (clear_status) begin
            expired_status <= 1'b0;
        end
    end

    always_comb begin
        read_value = '0;
        case (offset)
            REG_CTRL: read_value[1:0] = {irq_enable, enable};
            REG_RELOAD: read_value = reload;
            REG_COUNT: read_value = timer.count;
            REG_STATUS: read_value[0] = expired_status;
            REG_SCRATCH: read_value = scratch;
            default: read_value = '0;
        endcase
    end

    // Read response one cycle after the strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            bus.read_valid <= 1'b0;
        end else begin
            bus.read_valid <= bus.read_strobe;
        end
    end

    always_ff @(posedge clock) begin
        if (bus.read_strobe) begin
            bus.read_data <= read_value;
        end
    end

endmodule

/* src/simplebus_interconnect.sv */
`include "simplebus_defs.svh"

module simplebus_interconnect
    import simplebus_pkg::*;
(
    input logic clock,
    input logic reset,
    simplebus_if.slave master_1,
    simplebus_if.slave master_2,
    simplebus_if.slave master_3,
    simplebus_if.master slave
);

    logic request_1;
    logic request_2;
    logic request_3;

    sb_op_t select_op;
    master_id_t select_id;
    logic [`SB_ADDR_WIDTH-1:0] select_address;
    logic [`SB_DATA_WIDTH-1:0] select_write_data;

    sb_op_t s1_op;
    master_id_t s1_id;
    logic [`SB_ADDR_WIDTH-1:0] s1_address;
    logic [`SB_DATA_WIDTH-1:0] s1_write_data;
    logic s1_in_window;

    sb_op_t s2_op;
    master_id_t s2_id;
    logic s2_error;
    logic s2_read_strobe;
    logic s2_write_strobe;
    logic [`SB_ADDR_WIDTH-1:0] s2_address;
    logic [`SB_DATA_WIDTH-1:0] s2_write_data;

    sb_op_t s3_op;
    master_id_t s3_id;
    logic s3_error;

    logic response_valid;
    logic [`SB_DATA_WIDTH-1:0] response_data;

    assign request_1 = master_1.read_strobe | master_1.write_strobe;
    assign request_2 = master_2.read_strobe | master_2.write_strobe;
    assign request_3 = master_3.read_strobe | master_3.write_strobe;

    // Fixed priority, a lower-ranked master waits while a higher one strobes
    assign master_1.ready = slave.ready;
    assign master_2.ready = slave.ready & ~request_1;
    assign master_3.ready = slave.ready & ~request_1 & ~request_2;

    always_comb begin
        select_op = SB_IDLE;
        select_id = MASTER_1;
        select_address = master_1.address;
        select_write_data = master_1.write_data;
        if (slave.ready) begin
            if (request_1) begin
                select_op = master_1.write_strobe ? SB_WRITE : SB_READ;
            end else if (request_2) begin
                select_op = master_2.write_strobe ? SB_WRITE : SB_READ;
                select_id = MASTER_2;
                select_address = master_2.address;
                select_write_data = master_2.write_data;
            end else if (request_3) begin
                select_op = master_3.write_strobe ? SB_WRITE : SB_READ;
                select_id = MASTER_3;
                select_address = master_3.address;
                select_write_data = master_3.write_data;
            end
        end
    end

    // Stage 1 holds the accepted request
    always_ff @(posedge clock) begin
        s1_address <= select_address;
        s1_write_data <= select_write_data;
        if (reset) begin
            s1_op <= SB_IDLE;
            s1_id <= MASTER_1;
        end else begin
            s1_op <= select_op;
            s1_id <= select_id;
        end
    end

    assign s1_in_window = (s1_address >= `TIMER_BASE) && (s1_address < `TIMER_LIMIT);

    // Stage 2 faces the slave, a miss turns into an idle slot with an error tag
    always_ff @(posedge clock) begin
        s2_address <= s1_address;
        s2_write_data <= s1_write_data;
        if (reset) begin
            s2_op <= SB_IDLE;
            s2_id <= MASTER_1;
            s2_error <= 1'b0;
            s2_read_strobe <= 1'b0;
            s2_write_strobe <= 1'b0;
        end else begin
            s2_op <= s1_op;
            s2_id <= s1_id;
            s2_error <= !s1_in_window && (s1_op != SB_IDLE);
            s2_read_strobe <= s1_in_window && (s1_op == SB_READ);
            s2_write_strobe <= s1_in_window && (s1_op == SB_WRITE);
        end
    end

    assign slave.address = s2_address;
    assign slave.read_strobe = s2_read_strobe;
    assign slave.write_strobe = s2_write_strobe;
    assign slave.write_data = s2_write_data;

    // Stage 3 tag lines up with the slave's read response
    always_ff @(posedge clock) begin
        if (reset) begin
            s3_op <= SB_IDLE;
            s3_id <= MASTER_1;
            s3_error <= 1'b0;
        end else begin
            s3_op <= s2_op;
            s3_id <= s2_id;
            s3_error <= s2_error;
        end
    end

    assign response_valid = (s3_op == SB_READ) && (s3_error || slave.read_valid);
    assign response_data = s3_error ? `SB_DECODE_ERROR_DATA : slave.read_data;

    // Only the issuing master sees the response
    assign master_1.read_valid = response_valid && (s3_id == MASTER_1);
    assign master_2.read_valid = response_valid && (s3_id == MASTER_2);
    assign master_3.read_valid = response_valid && (s3_id == MASTER_3);
    assign master_1.read_data = (s3_id == MASTER_1) ? response_data : '0;
    assign master_2.read_data = (s3_id == MASTER_2) ? response_data : '0;
    assign master_3.read_data = (s3_id == MASTER_3) ? response_data : '0;

endmodule

/* src/timer_ctrl_if.sv */
`include "simplebus_defs.svh"

interface timer_ctrl_if;

    // Set up by the register block
    logic enable;
    logic [`SB_DATA_WIDTH-1:0] reload;

    // Reported back by the counter
    logic [`SB_DATA_WIDTH-1:0] count;
    logic expired;

    modport regs (
        output enable,
        output reload,
        input count,
        input expired
    );

    modport core (
        input enable,
        input reload,
        output count,
        output expired
    );

endinterface

/* src/simplebus_if.sv */
`include "simplebus_defs.svh"

interface simplebus_if;

    // Request side, driven by the master
    logic [`SB_ADDR_WIDTH-1:0] address;
    logic read_strobe;
    logic write_strobe;
    logic [`SB_DATA_WIDTH-1:0] write_data;

    // Response side, driven by the slave
    logic [`SB_DATA_WIDTH-1:0] read_data;
    logic read_valid;
    logic ready;

    modport master (
        output address,
        output read_strobe,
        output write_strobe,
        output write_data,
        input read_data,
        input read_valid,
        input ready
    );

    modport slave (
        input address,
        input read_strobe,
        input write_strobe,
        input write_data,
        output read_data,
        output read_valid,
        output ready
    );

endinterface

/* src/simplebus_pkg.sv */
package simplebus_pkg;

    // Operation held in each interconnect pipeline stage
    typedef enum logic [1:0] {
        SB_IDLE = 2'b00,
        SB_READ = 2'b01,
        SB_WRITE = 2'b10
    } sb_op_t;

    // Issuing master, carried along so responses find their way back
    typedef enum logic [1:0] {
        MASTER_1 = 2'd0,
        MASTER_2 = 2'd1,
        MASTER_3 = 2'd2
    } master_id_t;

    // Byte offsets of the timer registers inside the slave window
    typedef enum logic [4:0] {
        REG_CTRL = 5'h00,
        REG_RELOAD = 5'h04,
        REG_COUNT = 5'h08,
        REG_STATUS = 5'h0C,
        REG_SCRATCH = 5'h10
    } timer_reg_t;

endpackage

/* src/simplebus_defs.svh */
`ifndef SIMPLEBUS_DEFS_SVH
`define SIMPLEBUS_DEFS_SVH

// Bus widths shared by every simple-bus port
`define SB_ADDR_WIDTH 32
`define SB_DATA_WIDTH 32

// Timer slave window, base inclusive and limit exclusive
`define TIMER_BASE 32'h4000_0000
`define TIMER_LIMIT 32'h4000_0020

// Returned by the interconnect for reads that miss every window
`define SB_DECODE_ERROR_DATA 32'hDEAD_BEEF

`endif
